// ==== design/clos_params.svh ====
// sizes of the synchronous data Clos network
// CLOS_NN must equal CLOS_MN, since central module i drives sub-channel i
// of every output port and there are no output modules
// CLOS_PORTS is fixed by the five-port router and is not a free choice
`ifndef CLOS_PARAMS_SVH
`define CLOS_PARAMS_SVH

// number of central modules
`define CLOS_MN 2

// sub-channels per router port, equal to CLOS_MN
`define CLOS_NN 2

// data width of one sub-channel
`define CLOS_DW 8

// south, west, north, east, local
`define CLOS_PORTS 5

`endif

// ==== design/clos_pkg.sv ====
// port indices and central configuration word layout
// south and north outputs only turn from the opposite port or local
package clos_pkg;

   typedef enum logic [2:0] {
      dir_south = 3'd0,
      dir_west  = 3'd1,
      dir_north = 3'd2,
      dir_east  = 3'd3,
      dir_local = 3'd4
   } port_dir_e;

   // bit position in a central configuration word
   // four-bit words list the other four ports in port order
   typedef enum logic [1:0] {
      src_first  = 2'd0,  // opposite port in a two-bit word
      src_second = 2'd1,  // local in a two-bit word
      src_third  = 2'd2,
      src_fourth = 2'd3
   } src_sel_e;

   // source port behind bit b of the word for output d
   function automatic port_dir_e src_port(port_dir_e d, src_sel_e b);
      logic [2:0] p;
      if (d == dir_south || d == dir_north) begin
         if (b == src_first) begin
            p = (d == dir_south) ? dir_north : dir_south;
         end else begin
            p = dir_local;
         end
      end else begin
         p = ({1'b0, b} < d) ? {1'b0, b} : {1'b0, b} + 3'd1;  // skip own port
      end
      return port_dir_e'(p);
   endfunction

endpackage

// ==== design/input_switch.sv ====
// input module of the Clos network, NN sub-channels onto MN registered outputs
// cfg[m][n] set routes sub-channel n to output m, one flit held per output
// cfg is static while traffic flows; unselected sub-channels see ready low
`timescale 1ns/1ps
`include "clos_params.svh"

module input_switch (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [`CLOS_NN-1:0]               in_valid,
   input  logic [`CLOS_NN-1:0]               in_eof,
   input  logic [`CLOS_NN-1:0][`CLOS_DW-1:0] in_data,
   output logic [`CLOS_NN-1:0]               in_ready,
   input  logic [`CLOS_MN-1:0][`CLOS_NN-1:0] cfg,
   output logic [`CLOS_MN-1:0]               out_valid,
   output logic [`CLOS_MN-1:0]               out_eof,
   output logic [`CLOS_MN-1:0][`CLOS_DW-1:0] out_data,
   input  logic [`CLOS_MN-1:0]               out_ready
);

   logic [`CLOS_MN-1:0]               load_ok;  // register empty or draining
   logic [`CLOS_MN-1:0]               take;     // flit enters the register
   logic [`CLOS_MN-1:0]               mux_eof;
   logic [`CLOS_MN-1:0][`CLOS_DW-1:0] mux_data;
   logic [`CLOS_NN-1:0][`CLOS_MN-1:0] cfg_t;    // selection seen per sub-channel

   assign load_ok = ~out_valid | out_ready;

   always_comb begin
      for (int n = 0; n < `CLOS_NN; n++) begin
         for (int m = 0; m < `CLOS_MN; m++) begin
            cfg_t[n][m] = cfg[m][n];
         end
      end
   end

   // low when nothing selects the sub-channel, else AND over all selecting outputs
   always_comb begin
      for (int n = 0; n < `CLOS_NN; n++) begin
         in_ready[n] = (|cfg_t[n]) & (&(~cfg_t[n] | load_ok));
      end
   end

   always_comb begin
      for (int m = 0; m < `CLOS_MN; m++) begin
         take[m]     = |(cfg[m] & in_valid & in_ready);
         mux_eof[m]  = 1'b0;
         mux_data[m] = '0;
         for (int n = 0; n < `CLOS_NN; n++) begin
            if (cfg[m][n]) begin
               mux_eof[m]  = in_eof[n];
               mux_data[m] = in_data[n];
            end
         end
      end
   end

   // full flags
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= '0;
      end else begin
         for (int m = 0; m < `CLOS_MN; m++) begin
            if (load_ok[m]) begin
               out_valid[m] <= take[m];  // refill as the old flit leaves
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int m = 0; m < `CLOS_MN; m++) begin
         if (load_ok[m] && take[m]) begin
            out_data[m] <= mux_data[m];
            out_eof[m]  <= mux_eof[m];
         end
      end
   end

   for (genvar m = 0; m < `CLOS_MN; m++) begin : g_out_chk
      a_cfg_onehot: assert property (@(posedge clk) disable iff (rst)
         $onehot0(cfg[m]));

      // stalled flit must stay put until the central module takes it
      a_hold: assert property (@(posedge clk) disable iff (rst)
         out_valid[m] && !out_ready[m] |=>
            out_valid[m] && $stable(out_data[m]) && $stable(out_eof[m]));
   end

   for (genvar n = 0; n < `CLOS_NN; n++) begin : g_in_chk
      a_no_share: assert property (@(posedge clk) disable iff (rst)
         $onehot0(cfg_t[n]));
   end

endmodule

// ==== design/central_switch.sv ====
// central module of the Clos network, a five-way switch with XY turn limits
// south and north outputs take only the opposite port or local (2-bit words)
// west, east and local outputs take any other port (4-bit words, see src_sel_e)
// zero word leaves the output idle; one flit held per output
`timescale 1ns/1ps
`include "clos_params.svh"

module central_switch
   import clos_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [`CLOS_PORTS-1:0]               in_valid,
   input  logic [`CLOS_PORTS-1:0]               in_eof,
   input  logic [`CLOS_PORTS-1:0][`CLOS_DW-1:0] in_data,
   output logic [`CLOS_PORTS-1:0]               in_ready,
   input  logic [1:0]                           s_cfg,
   input  logic [1:0]                           n_cfg,
   input  logic [3:0]                           w_cfg,
   input  logic [3:0]                           e_cfg,
   input  logic [3:0]                           l_cfg,
   output logic [`CLOS_PORTS-1:0]               out_valid,
   output logic [`CLOS_PORTS-1:0]               out_eof,
   output logic [`CLOS_PORTS-1:0][`CLOS_DW-1:0] out_data,
   input  logic [`CLOS_PORTS-1:0]               out_ready
);

   logic [`CLOS_PORTS-1:0][3:0]              cfg_w;  // words indexed by output
   logic [`CLOS_PORTS-1:0][`CLOS_PORTS-1:0]  sel;    // sel[d][p], output d from p
   logic [`CLOS_PORTS-1:0][`CLOS_PORTS-1:0]  sel_t;  // sel_t[p][d]
   logic [`CLOS_PORTS-1:0]                   load_ok;
   logic [`CLOS_PORTS-1:0]                   take;
   logic [`CLOS_PORTS-1:0]                   mux_eof;
   logic [`CLOS_PORTS-1:0][`CLOS_DW-1:0]     mux_data;

   assign cfg_w[dir_south] = {2'b00, s_cfg};
   assign cfg_w[dir_west]  = w_cfg;
   assign cfg_w[dir_north] = {2'b00, n_cfg};
   assign cfg_w[dir_east]  = e_cfg;
   assign cfg_w[dir_local] = l_cfg;

   // turn rules live in src_port, so illegal turns cannot be encoded
   always_comb begin
      sel = '0;
      for (int d = 0; d < `CLOS_PORTS; d++) begin
         for (int k = 0; k < 4; k++) begin
            if (cfg_w[d][k]) begin
               sel[d][src_port(port_dir_e'(d), src_sel_e'(k))] = 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int p = 0; p < `CLOS_PORTS; p++) begin
         for (int d = 0; d < `CLOS_PORTS; d++) begin
            sel_t[p][d] = sel[d][p];
         end
      end
   end

   assign load_ok = ~out_valid | out_ready;

   always_comb begin
      for (int p = 0; p < `CLOS_PORTS; p++) begin
         in_ready[p] = (|sel_t[p]) & (&(~sel_t[p] | load_ok));  // low if unused
      end
   end

   always_comb begin
      for (int d = 0; d < `CLOS_PORTS; d++) begin
         take[d]     = |(sel[d] & in_valid & in_ready);
         mux_eof[d]  = 1'b0;
         mux_data[d] = '0;
         for (int p = 0; p < `CLOS_PORTS; p++) begin
            if (sel[d][p]) begin
               mux_eof[d]  = in_eof[p];
               mux_data[d] = in_data[p];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= '0;
      end else begin
         for (int d = 0; d < `CLOS_PORTS; d++) begin
            if (load_ok[d]) begin
               out_valid[d] <= take[d];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int d = 0; d < `CLOS_PORTS; d++) begin
         if (load_ok[d] && take[d]) begin
            out_data[d] <= mux_data[d];
            out_eof[d]  <= mux_eof[d];
         end
      end
   end

   // one source per output word
   for (genvar d = 0; d < `CLOS_PORTS; d++) begin : g_cfg_chk
      a_cfg_onehot: assert property (@(posedge clk) disable iff (rst)
         $onehot0(cfg_w[d]));
   end

   // a circuit never forks inside the central stage
   for (genvar p = 0; p < `CLOS_PORTS; p++) begin : g_src_chk
      a_no_fork: assert property (@(posedge clk) disable iff (rst)
         $onehot0(sel_t[p]));
   end

endmodule

// ==== design/clos_fabric.sv ====
// data Clos network of a five-port router, synchronous valid/ready flits
// five input modules feed MN central modules; no output modules
// input to output latency is two cycles; cfg may change only when idle
`timescale 1ns/1ps
`include "clos_params.svh"

module clos_fabric
   import clos_pkg::*;
(
   input  logic                                               clk,
   input  logic                                               rst,
   input  logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0]               in_valid,
   input  logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0]               in_eof,
   input  logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0][`CLOS_DW-1:0] in_data,
   output logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0]               in_ready,
   output logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0]               out_valid,
   output logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0]               out_eof,
   output logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0][`CLOS_DW-1:0] out_data,
   input  logic [`CLOS_PORTS-1:0][`CLOS_NN-1:0]               out_ready,
   input  logic [`CLOS_PORTS-1:0][`CLOS_MN-1:0][`CLOS_NN-1:0] im_cfg,
   input  logic [`CLOS_MN-1:0][1:0]                           s_cfg,
   input  logic [`CLOS_MN-1:0][1:0]                           n_cfg,
   input  logic [`CLOS_MN-1:0][3:0]                           w_cfg,
   input  logic [`CLOS_MN-1:0][3:0]                           e_cfg,
   input  logic [`CLOS_MN-1:0][3:0]                           l_cfg
);

   // input module side, [port][central]
   logic [`CLOS_PORTS-1:0][`CLOS_MN-1:0]               im_valid;
   logic [`CLOS_PORTS-1:0][`CLOS_MN-1:0]               im_eof;
   logic [`CLOS_PORTS-1:0][`CLOS_MN-1:0][`CLOS_DW-1:0] im_data;
   logic [`CLOS_PORTS-1:0][`CLOS_MN-1:0]               im_ready;

   // central module side, [central][port]
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0]               cm_in_valid;
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0]               cm_in_eof;
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0][`CLOS_DW-1:0] cm_in_data;
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0]               cm_in_ready;
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0]               cm_out_valid;
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0]               cm_out_eof;
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0][`CLOS_DW-1:0] cm_out_data;
   logic [`CLOS_MN-1:0][`CLOS_PORTS-1:0]               cm_out_ready;

   for (genvar p = dir_south; p <= dir_local; p++) begin : g_im
      input_switch u_im (
         .clk       (clk),
         .rst       (rst),
         .in_valid  (in_valid[p]),
         .in_eof    (in_eof[p]),
         .in_data   (in_data[p]),
         .in_ready  (in_ready[p]),
         .cfg       (im_cfg[p]),
         .out_valid (im_valid[p]),
         .out_eof   (im_eof[p]),
         .out_data  (im_data[p]),
         .out_ready (im_ready[p])
      );

      // IM p output i -> CM i input p
      for (genvar i = 0; i < `CLOS_MN; i++) begin : g_shf
         assign cm_in_valid[i][p] = im_valid[p][i];
         assign cm_in_eof[i][p]   = im_eof[p][i];
         assign cm_in_data[i][p]  = im_data[p][i];
         assign im_ready[p][i]    = cm_in_ready[i][p];
      end
   end

   for (genvar i = 0; i < `CLOS_MN; i++) begin : g_cm
      central_switch u_cm (
         .clk       (clk),
         .rst       (rst),
         .in_valid  (cm_in_valid[i]),
         .in_eof    (cm_in_eof[i]),
         .in_data   (cm_in_data[i]),
         .in_ready  (cm_in_ready[i]),
         .s_cfg     (s_cfg[i]),
         .n_cfg     (n_cfg[i]),
         .w_cfg     (w_cfg[i]),
         .e_cfg     (e_cfg[i]),
         .l_cfg     (l_cfg[i]),
         .out_valid (cm_out_valid[i]),
         .out_eof   (cm_out_eof[i]),
         .out_data  (cm_out_data[i]),
         .out_ready (cm_out_ready[i])
      );

      // CM i output d is sub-channel i of port d
      for (genvar d = dir_south; d <= dir_local; d++) begin : g_out
         assign out_valid[d][i]    = cm_out_valid[i][d];
         assign out_eof[d][i]      = cm_out_eof[i][d];
         assign out_data[d][i]     = cm_out_data[i][d];
         assign cm_out_ready[i][d] = out_ready[d][i];
      end
   end

endmodule

// ==== tests/clos_fabric_tb.sv ====
// testbench for clos_fabric, static circuits carrying random frames
// configs alternate per central module and assume CLOS_MN == CLOS_NN >= 2
// back-pressure is applied to even flat output indices only
`timescale 1ns/1ps
`include "clos_params.svh"

module clos_fabric_tb
   import clos_pkg::*;
();

   localparam int NP = `CLOS_PORTS;
   localparam int NN = `CLOS_NN;
   localparam int MN = `CLOS_MN;
   localparam int DW = `CLOS_DW;
   localparam int NOUT = NP * NN;  // flat index p*NN+n on both sides
   localparam int FLITS = 24;      // per source per test
   localparam int MAX_CYCLES = 4 * FLITS * (3 * NOUT + 2 * NN) + 200;

   logic                          clk;
   logic                          rst;
   logic [NP-1:0][NN-1:0]         in_valid;
   logic [NP-1:0][NN-1:0]         in_eof;
   logic [NP-1:0][NN-1:0][DW-1:0] in_data;
   logic [NP-1:0][NN-1:0]         in_ready;
   logic [NP-1:0][NN-1:0]         out_valid;
   logic [NP-1:0][NN-1:0]         out_eof;
   logic [NP-1:0][NN-1:0][DW-1:0] out_data;
   logic [NP-1:0][NN-1:0]         out_ready;
   logic [NP-1:0][MN-1:0][NN-1:0] im_cfg;
   logic [MN-1:0][1:0]            s_cfg;
   logic [MN-1:0][1:0]            n_cfg;
   logic [MN-1:0][3:0]            w_cfg;
   logic [MN-1:0][3:0]            e_cfg;
   logic [MN-1:0][3:0]            l_cfg;

   int              seed = 32'h30378951;
   int              cycle = 0;
   int              checks = 0;
   int              errors = 0;
   string           test_name = "after_reset";
   bit              check_lat = 1'b0;
   int              dst_of [NOUT];   // source to output, -1 when unrouted
   logic [NOUT-1:0] routed;
   logic [DW:0]     exp_q [NOUT][$];  // {eof, data} in order per output
   int              exp_t [NOUT][$];  // acceptance cycle

   clos_fabric u_dut (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_eof    (in_eof),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_eof   (out_eof),
      .out_data  (out_data),
      .out_ready (out_ready),
      .im_cfg    (im_cfg),
      .s_cfg     (s_cfg),
      .n_cfg     (n_cfg),
      .w_cfg     (w_cfg),
      .e_cfg     (e_cfg),
      .l_cfg     (l_cfg)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // source of output port d sub-channel i as p*NN+n, or -1 when idle
   function automatic int ref_src(int d, int i);
      port_dir_e  dd;
      logic [3:0] w;
      int         p;
      dd = port_dir_e'(d);
      p = -1;
      case (dd)
         dir_south: w = {2'b00, s_cfg[i]};
         dir_north: w = {2'b00, n_cfg[i]};
         dir_west:  w = w_cfg[i];
         dir_east:  w = e_cfg[i];
         default:   w = l_cfg[i];
      endcase
      if (dd == dir_south || dd == dir_north) begin
         if (w[src_first]) begin
            p = (dd == dir_south) ? int'(dir_north) : int'(dir_south);  // opposite
         end else if (w[src_second]) begin
            p = int'(dir_local);
         end
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (w[b]) begin
               p = (b < int'(dd)) ? b : b + 1;  // own port left out
            end
         end
      end
      if (p >= 0) begin
         for (int n = 0; n < NN; n++) begin
            if (im_cfg[p][i][n]) begin
               return p * NN + n;
            end
         end
      end
      return -1;
   endfunction

   // mode 0 and 1 are full permutations, 1 swaps sub-channels and words
   // mode 2 uses only south from north and north from local, other ports unselected
   task automatic set_cfg(input int mode);
      int src;
      for (int i = 0; i < MN; i++) begin
         for (int p = 0; p < NP; p++) begin
            im_cfg[p][i] = '0;
            if (mode != 2 || p == dir_north || p == dir_local) begin
               im_cfg[p][i][(mode == 1) ? NN - 1 - i : i] = 1'b1;
            end
         end
         if (mode == 2) begin
            s_cfg[i] = 2'b01;
            n_cfg[i] = 2'b10;
            w_cfg[i] = '0;
            e_cfg[i] = '0;
            l_cfg[i] = '0;
         end else if ((i + mode) % 2 == 0) begin
            s_cfg[i] = 2'b10;    // from local
            n_cfg[i] = 2'b01;    // from south
            w_cfg[i] = 4'b0010;  // from north
            e_cfg[i] = 4'b0010;  // from west
            l_cfg[i] = 4'b1000;  // from east
         end else begin
            s_cfg[i] = 2'b01;    // from north
            n_cfg[i] = 2'b10;    // from local
            w_cfg[i] = 4'b0100;  // from east
            e_cfg[i] = 4'b0010;  // from west
            l_cfg[i] = 4'b0001;  // from south
         end
      end
      routed = '0;
      for (int s = 0; s < NOUT; s++) begin
         dst_of[s] = -1;
      end
      for (int o = 0; o < NOUT; o++) begin
         src = ref_src(o / NN, o % NN);
         if (src >= 0) begin
            dst_of[src] = o;
            routed[src] = 1'b1;
         end
      end
   endtask

   // compare at the outputs first, then record flits accepted at the inputs
   always @(posedge clk) begin : compare
      logic [DW:0] want;
      int          t;
      if (!rst) begin
         for (int o = 0; o < NOUT; o++) begin
            if (out_valid[o / NN][o % NN] && out_ready[o / NN][o % NN]) begin
               if (exp_q[o].size() == 0) begin
                  errors++;
                  $display("%s: unexpected flit on port %0d sub-channel %0d",
                           test_name, o / NN, o % NN);
               end else begin
                  want = exp_q[o].pop_front();
                  t = exp_t[o].pop_front();
                  check({test_name, " data"}, 64'(want[DW-1:0]),
                        64'(out_data[o / NN][o % NN]));
                  check({test_name, " eof"}, 64'(want[DW]), 64'(out_eof[o / NN][o % NN]));
                  if (check_lat) begin
                     check({test_name, " latency"}, 64'(2), 64'(cycle - t));
                  end
               end
            end
         end
         for (int s = 0; s < NOUT; s++) begin
            if (in_valid[s / NN][s % NN] && in_ready[s / NN][s % NN]) begin
               if (dst_of[s] < 0) begin
                  errors++;
                  $display("%s: flit accepted on unrouted port %0d sub-channel %0d",
                           test_name, s / NN, s % NN);
               end else begin
                  exp_q[dst_of[s]].push_back({in_eof[s / NN][s % NN], in_data[s / NN][s % NN]});
                  exp_t[dst_of[s]].push_back(cycle);
                  if (exp_q[dst_of[s]].size() > 2) begin
                     errors++;
                     $display("%s: more than two flits in flight toward output %0d",
                              test_name, dst_of[s]);
                  end
               end
            end
         end
      end
   end

   // called on a falling edge, returns on one
   task automatic stream(input int nflits, input bit bp);
      int              left [NOUT];
      int              flen [NOUT];
      logic [NOUT-1:0] done;
      logic [31:0]     rnd;
      bit              busy;
      for (int s = 0; s < NOUT; s++) begin
         left[s] = routed[s] ? nflits : 0;
         flen[s] = 0;
         in_valid[s / NN][s % NN] = !routed[s];  // unselected input, must stall
         in_eof[s / NN][s % NN] = 1'b1;
      end
      done = '0;
      busy = 1'b1;
      while (busy) begin
         busy = 1'b0;
         for (int s = 0; s < NOUT; s++) begin
            if (routed[s] && (!in_valid[s / NN][s % NN] || done[s])) begin
               in_valid[s / NN][s % NN] = 1'b0;
               if (left[s] > 0) begin
                  rnd = $random(seed);
                  if (flen[s] == 0) begin
                     flen[s] = 1 + int'(rnd[9:8]);  // frames of 1 to 4 flits
                  end
                  in_valid[s / NN][s % NN] = 1'b1;
                  in_data[s / NN][s % NN] = rnd[DW-1:0];
                  in_eof[s / NN][s % NN] = (flen[s] == 1) || (left[s] == 1);
                  flen[s]--;
                  left[s]--;
               end
            end
            busy = busy | (routed[s] & in_valid[s / NN][s % NN]);
         end
         for (int o = 0; o < NOUT; o += 2) begin
            rnd = $random(seed);
            out_ready[o / NN][o % NN] = !bp || rnd[0];
         end
         @(posedge clk);
         done = in_valid & in_ready;
         @(negedge clk);
      end
      in_valid = '0;
      out_ready = '1;
   endtask

   function automatic int pending();
      int n;
      n = 0;
      for (int o = 0; o < NOUT; o++) begin
         n += exp_q[o].size();
      end
      return n;
   endfunction

   task automatic drain();
      int waited;
      int left;
      waited = 0;
      left = pending();
      while (left != 0 && waited < 64) begin
         @(negedge clk);
         waited++;
         left = pending();
      end
      repeat (4) @(negedge clk);  // room for a stray flit to show up
      left = pending();
      if (left != 0) begin
         errors++;
         $display("%s: %0d expected flits never arrived", test_name, left);
         for (int o = 0; o < NOUT; o++) begin
            exp_q[o].delete();
            exp_t[o].delete();
         end
      end
   endtask

   task automatic run_test(input string name, input int mode, input bit bp);
      int e0;
      int c0;
      e0 = errors;
      c0 = checks;
      set_cfg(mode);  // fabric is idle here
      test_name = name;
      check_lat = !bp;
      stream(FLITS, bp);
      drain();
      $display("%s done: %0d checks, %0d errors", name, checks - c0, errors - e0);
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      in_valid = '0;
      in_eof = '0;
      in_data = '0;
      out_ready = '1;
      set_cfg(0);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check("after_reset out_valid", 64'(0), 64'(out_valid));
      check("after_reset in_ready", 64'(routed), 64'(in_ready));
      $display("after_reset done: %0d checks, %0d errors", checks, errors);
      run_test("permutation", 0, 1'b0);
      run_test("turn_limits", 2, 1'b0);
      run_test("back_pressure", 0, 1'b1);
      run_test("reconfig", 1, 1'b0);
      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== clos_fabric.f ====
+incdir+design
design/clos_pkg.sv
design/input_switch.sv
design/central_switch.sv
design/clos_fabric.sv
tests/clos_fabric_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= clos_fabric_tb
RTL_TOP   ?= clos_fabric
FLIST     ?= clos_fabric.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
